//--- day05_defs.svh
`ifndef DAY05_DEFS_SVH
`define DAY05_DEFS_SVH

// width of every parsed number and bound
`define D05_VAL_W 64

// depth of the raw and merged range RAMs
`define D05_MAX_RANGES 180

// width of a range index or range count
`define D05_IDX_W 8

// byte address into the puzzle ROM
`define D05_ROM_ADDR_W 17

`endif

//--- day05_pkg.sv
`default_nettype none

`include "day05_defs.svh"

package day05_pkg;

    // one stored range with the lower bound in the upper half
    typedef struct packed {
        logic [`D05_VAL_W-1:0] lo;
        logic [`D05_VAL_W-1:0] hi;
    } range_t;

    typedef struct packed {
        logic [`D05_IDX_W-1:0] addr;
        logic                  we;
        range_t                wdata;
    } ram_req_t;

    typedef enum logic [2:0] {PH_RANGES, PH_SORT, PH_MERGE, PH_VALUES, PH_DONE} phase_e;

    typedef enum logic [1:0] {P_RUN, P_EMIT, P_HOLD, P_END} parser_state_e;

    typedef enum logic [2:0] {
        SO_IDLE, SO_OUTER, SO_INNER, SO_READ_A, SO_READ_B, SO_CMP, SO_SWAP, SO_FIN
    } sort_state_e;

    typedef enum logic [1:0] {MG_IDLE, MG_WAIT, MG_CHECK, MG_LAST} merge_state_e;

    typedef enum logic [1:0] {SR_IDLE, SR_CHECK, SR_READ, SR_EVAL} search_state_e;

endpackage

`default_nettype wire

//--- range_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module range_ram
    import day05_pkg::*;
#(
    parameter int DEPTH = `D05_MAX_RANGES,
    parameter int IDX_W = `D05_IDX_W
) (
    input  wire logic     clk,
    input  wire ram_req_t req,
    output range_t        rdata
);

    range_t           mem [DEPTH];
    logic [IDX_W-1:0] addr;

    assign addr = req.addr[IDX_W-1:0];

    // read data shows up one cycle after the address
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[addr] <= req.wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- input_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module input_parser
    import day05_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    output logic [`D05_ROM_ADDR_W-1:0]     rom_addr,
    input  wire logic [7:0]                rom_data,
    input  wire logic                      rom_valid,
    input  wire logic                      resume,
    input  wire logic                      search_done,
    output logic                           range_valid,
    output range_t                         range_out,
    output logic                           ranges_end,
    output logic                           id_valid,
    output logic [`D05_VAL_W-1:0]          id_value,
    output logic                           input_end
);

    parser_state_e         state;
    logic [`D05_VAL_W-1:0] cur;
    logic [`D05_VAL_W-1:0] lo_val;
    logic [`D05_VAL_W-1:0] next_val;
    logic                  has_digit;
    logic                  in_ranges;
    logic                  eof_seen;
    logic                  is_digit;

    assign is_digit = (rom_data >= 8'h30) && (rom_data <= 8'h39);

    // low nibble of an ascii digit is its value
    assign next_val = cur * `D05_VAL_W'(10) + {{(`D05_VAL_W-4){1'b0}}, rom_data[3:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= P_RUN;
            rom_addr    <= '0;
            cur         <= '0;
            has_digit   <= 1'b0;
            in_ranges   <= 1'b1;
            eof_seen    <= 1'b0;
            range_valid <= 1'b0;
            ranges_end  <= 1'b0;
            id_valid    <= 1'b0;
            input_end   <= 1'b0;
        end else begin
            range_valid <= 1'b0;
            ranges_end  <= 1'b0;
            id_valid    <= 1'b0;
            input_end   <= 1'b0;

            case (state)
                P_RUN: begin
                    if (!rom_valid) begin
                        // an id without a trailing newline still gets searched
                        if (!in_ranges && has_digit) begin
                            id_value <= cur;
                            id_valid <= 1'b1;
                            eof_seen <= 1'b1;
                            state    <= P_EMIT;
                        end else begin
                            input_end <= 1'b1;
                            state     <= P_END;
                        end
                    end else begin
                        rom_addr <= rom_addr + 1'b1;
                        if (is_digit) begin
                            cur       <= next_val;
                            has_digit <= 1'b1;
                        end else if (rom_data == 8'h2d) begin
                            lo_val    <= cur;
                            cur       <= '0;
                            has_digit <= 1'b0;
                        end else if (rom_data == 8'h0a) begin
                            cur       <= '0;
                            has_digit <= 1'b0;
                            if (in_ranges && has_digit) begin
                                range_out   <= '{lo: lo_val, hi: cur};
                                range_valid <= 1'b1;
                            end else if (in_ranges) begin
                                // blank line closes the range block
                                ranges_end <= 1'b1;
                                in_ranges  <= 1'b0;
                                state      <= P_HOLD;
                            end else if (has_digit) begin
                                id_value <= cur;
                                id_valid <= 1'b1;
                                state    <= P_EMIT;
                            end
                        end
                    end
                end

                P_EMIT: begin
                    if (search_done) begin
                        if (eof_seen) begin
                            input_end <= 1'b1;
                            state     <= P_END;
                        end else begin
                            state <= P_RUN;
                        end
                    end
                end

                P_HOLD: begin
                    if (resume) begin
                        state <= P_RUN;
                    end
                end

                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- range_sorter.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module range_sorter
    import day05_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire logic [`D05_IDX_W-1:0] count,
    output ram_req_t                   ram_req,
    input  wire range_t                ram_rdata,
    output logic                       sort_done
);

    sort_state_e           state;
    logic [`D05_IDX_W-1:0] pass_i;
    logic [`D05_IDX_W-1:0] pair_j;
    range_t                first;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SO_IDLE;
            ram_req   <= '0;
            pass_i    <= '0;
            pair_j    <= '0;
            sort_done <= 1'b0;
        end else begin
            ram_req.we <= 1'b0;
            sort_done  <= 1'b0;

            case (state)
                SO_IDLE: begin
                    if (start) begin
                        pass_i <= '0;
                        state  <= (count < 2) ? SO_FIN : SO_OUTER;
                    end
                end

                SO_OUTER: begin
                    if (pass_i >= count - 1'b1) begin
                        state <= SO_FIN;
                    end else begin
                        pair_j <= '0;
                        state  <= SO_INNER;
                    end
                end

                // the tail of each pass is already in place
                SO_INNER: begin
                    if (pair_j >= count - 1'b1 - pass_i) begin
                        pass_i <= pass_i + 1'b1;
                        state  <= SO_OUTER;
                    end else begin
                        ram_req.addr <= pair_j;
                        state        <= SO_READ_A;
                    end
                end

                SO_READ_A: begin
                    ram_req.addr <= pair_j + 1'b1;
                    state        <= SO_READ_B;
                end

                SO_READ_B: begin
                    first <= ram_rdata;
                    state <= SO_CMP;
                end

                // second of the pair is on ram_rdata now
                SO_CMP: begin
                    if (first.lo > ram_rdata.lo) begin
                        ram_req <= '{addr: pair_j, we: 1'b1, wdata: ram_rdata};
                        state   <= SO_SWAP;
                    end else begin
                        pair_j <= pair_j + 1'b1;
                        state  <= SO_INNER;
                    end
                end

                SO_SWAP: begin
                    ram_req <= '{addr: pair_j + 1'b1, we: 1'b1, wdata: first};
                    pair_j  <= pair_j + 1'b1;
                    state   <= SO_INNER;
                end

                SO_FIN: begin
                    sort_done <= 1'b1;
                    state     <= SO_IDLE;
                end

                default: state <= SO_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- range_merger.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module range_merger
    import day05_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire logic [`D05_IDX_W-1:0]  count,
    output ram_req_t                    raw_req,
    input  wire range_t                 raw_rdata,
    output ram_req_t                    merged_req,
    output logic [`D05_IDX_W-1:0]       merged_count,
    output logic [`D05_VAL_W-1:0]       part2_result,
    output logic                        merge_done
);

    merge_state_e          state;
    logic [`D05_IDX_W-1:0] idx;
    range_t                open_r;
    logic                  joins;
    logic [`D05_VAL_W-1:0] open_size;

    // one extra bit so a bound at the very top does not wrap
    assign joins     = {1'b0, raw_rdata.lo} <= {1'b0, open_r.hi} + 1'b1;
    assign open_size = open_r.hi - open_r.lo + 1'b1;
    assign raw_req   = '{addr: idx, we: 1'b0, wdata: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= MG_IDLE;
            idx          <= '0;
            merged_req   <= '0;
            merged_count <= '0;
            part2_result <= '0;
            merge_done   <= 1'b0;
        end else begin
            merged_req.we <= 1'b0;
            merge_done    <= 1'b0;

            case (state)
                MG_IDLE: begin
                    if (start) begin
                        idx <= '0;
                        if (count == 0) begin
                            merge_done <= 1'b1;
                        end else begin
                            state <= MG_WAIT;
                        end
                    end
                end

                MG_WAIT: state <= MG_CHECK;

                MG_CHECK: begin
                    if (idx == 0) begin
                        open_r <= raw_rdata;
                    end else if (joins) begin
                        if (raw_rdata.hi > open_r.hi) begin
                            open_r.hi <= raw_rdata.hi;
                        end
                    end else begin
                        merged_req   <= '{addr: merged_count, we: 1'b1, wdata: open_r};
                        merged_count <= merged_count + 1'b1;
                        part2_result <= part2_result + open_size;
                        open_r       <= raw_rdata;
                    end
                    if (idx == count - 1'b1) begin
                        state <= MG_LAST;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= MG_WAIT;
                    end
                end

                // the range still open is the last one
                MG_LAST: begin
                    merged_req   <= '{addr: merged_count, we: 1'b1, wdata: open_r};
                    merged_count <= merged_count + 1'b1;
                    part2_result <= part2_result + open_size;
                    merge_done   <= 1'b1;
                    state        <= MG_IDLE;
                end

                default: state <= MG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- interval_search.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module interval_search
    import day05_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  id_valid,
    input  wire logic [`D05_VAL_W-1:0] id_value,
    input  wire logic [`D05_IDX_W-1:0] merged_count,
    output ram_req_t                   ram_req,
    input  wire range_t                ram_rdata,
    output logic [`D05_VAL_W-1:0]      part1_result,
    output logic                       search_done
);

    search_state_e         state;
    logic [`D05_VAL_W-1:0] key;
    logic [`D05_IDX_W-1:0] low;
    logic [`D05_IDX_W-1:0] high;
    logic [`D05_IDX_W-1:0] mid;

    assign ram_req = '{addr: mid, we: 1'b0, wdata: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= SR_IDLE;
            low          <= '0;
            high         <= '0;
            mid          <= '0;
            part1_result <= '0;
            search_done  <= 1'b0;
        end else begin
            search_done <= 1'b0;

            case (state)
                SR_IDLE: begin
                    if (id_valid) begin
                        key  <= id_value;
                        low  <= '0;
                        high <= merged_count - 1'b1;
                        // nothing to search in an empty list
                        if (merged_count == 0) begin
                            search_done <= 1'b1;
                        end else begin
                            state <= SR_CHECK;
                        end
                    end
                end

                SR_CHECK: begin
                    if (low > high) begin
                        search_done <= 1'b1;
                        state       <= SR_IDLE;
                    end else begin
                        mid   <= low + ((high - low) >> 1);
                        state <= SR_READ;
                    end
                end

                SR_READ: state <= SR_EVAL;

                SR_EVAL: begin
                    if (key >= ram_rdata.lo && key <= ram_rdata.hi) begin
                        part1_result <= part1_result + 1'b1;
                        search_done  <= 1'b1;
                        state        <= SR_IDLE;
                    end else if (key < ram_rdata.lo) begin
                        if (mid == 0) begin
                            search_done <= 1'b1;
                            state       <= SR_IDLE;
                        end else begin
                            high  <= mid - 1'b1;
                            state <= SR_CHECK;
                        end
                    end else begin
                        low   <= mid + 1'b1;
                        state <= SR_CHECK;
                    end
                end

                default: state <= SR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- day05_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module day05_top
    import day05_pkg::*;
(
    input  wire logic                      clk,
    input  wire logic                      rst,
    output logic [`D05_ROM_ADDR_W-1:0]     rom_addr,
    input  wire logic [7:0]                rom_data,
    input  wire logic                      rom_valid,
    output logic [`D05_VAL_W-1:0]          part1_result,
    output logic [`D05_VAL_W-1:0]          part2_result,
    output logic                           done
);

    phase_e                phase;
    logic [`D05_IDX_W-1:0] n_ranges;
    logic [`D05_IDX_W-1:0] merged_count;
    logic [`D05_VAL_W-1:0] id_value;
    logic                  range_valid;
    logic                  ranges_end;
    logic                  id_valid;
    logic                  input_end;
    logic                  search_done;
    logic                  sort_done;
    logic                  merge_done;
    logic                  sort_start;
    logic                  merge_start;
    logic                  resume;
    range_t                range_out;
    range_t                raw_rdata;
    range_t                merged_rdata;
    ram_req_t              parse_req;
    ram_req_t              sort_req;
    ram_req_t              merge_raw_req;
    ram_req_t              merge_out_req;
    ram_req_t              search_req;
    ram_req_t              raw_req;
    ram_req_t              merged_req;

    // parsed ranges are appended at the current count
    assign parse_req = '{addr: n_ranges, we: range_valid, wdata: range_out};

    always_comb begin
        case (phase)
            PH_RANGES: raw_req = parse_req;
            PH_SORT:   raw_req = sort_req;
            default:   raw_req = merge_raw_req;
        endcase
    end

    assign merged_req = (phase == PH_MERGE) ? merge_out_req : search_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= PH_RANGES;
            n_ranges    <= '0;
            sort_start  <= 1'b0;
            merge_start <= 1'b0;
            resume      <= 1'b0;
            done        <= 1'b0;
        end else begin
            sort_start  <= 1'b0;
            merge_start <= 1'b0;
            resume      <= 1'b0;
            if (range_valid) begin
                n_ranges <= n_ranges + 1'b1;
            end
            case (phase)
                PH_RANGES: begin
                    if (ranges_end) begin
                        phase      <= PH_SORT;
                        sort_start <= 1'b1;
                    end
                end
                PH_SORT: begin
                    if (sort_done) begin
                        phase       <= PH_MERGE;
                        merge_start <= 1'b1;
                    end
                end
                PH_MERGE: begin
                    if (merge_done) begin
                        phase  <= PH_VALUES;
                        resume <= 1'b1;
                    end
                end
                default: ;
            endcase
            // end of input wins from any phase
            if (input_end) begin
                phase <= PH_DONE;
                done  <= 1'b1;
            end
        end
    end

    input_parser u_parser (
        .clk         (clk),
        .rst         (rst),
        .rom_addr    (rom_addr),
        .rom_data    (rom_data),
        .rom_valid   (rom_valid),
        .resume      (resume),
        .search_done (search_done),
        .range_valid (range_valid),
        .range_out   (range_out),
        .ranges_end  (ranges_end),
        .id_valid    (id_valid),
        .id_value    (id_value),
        .input_end   (input_end)
    );

    range_sorter u_sorter (
        .clk       (clk),
        .rst       (rst),
        .start     (sort_start),
        .count     (n_ranges),
        .ram_req   (sort_req),
        .ram_rdata (raw_rdata),
        .sort_done (sort_done)
    );

    range_merger u_merger (
        .clk          (clk),
        .rst          (rst),
        .start        (merge_start),
        .count        (n_ranges),
        .raw_req      (merge_raw_req),
        .raw_rdata    (raw_rdata),
        .merged_req   (merge_out_req),
        .merged_count (merged_count),
        .part2_result (part2_result),
        .merge_done   (merge_done)
    );

    interval_search u_search (
        .clk          (clk),
        .rst          (rst),
        .id_valid     (id_valid),
        .id_value     (id_value),
        .merged_count (merged_count),
        .ram_req      (search_req),
        .ram_rdata    (merged_rdata),
        .part1_result (part1_result),
        .search_done  (search_done)
    );

    range_ram raw_ram (
        .clk   (clk),
        .req   (raw_req),
        .rdata (raw_rdata)
    );

    range_ram merged_ram (
        .clk   (clk),
        .req   (merged_req),
        .rdata (merged_rdata)
    );

endmodule

`default_nettype wire

//--- tb_day05.sv
`timescale 1ns/1ps
`default_nettype none

`include "day05_defs.svh"

module tb_day05;

    localparam int NUM_RUNS        = 7;
    localparam int RUN_CYCLES      = 28000;
    localparam int DONE_TIMEOUT    = RUN_CYCLES - 100;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES * NUM_RUNS + 4000;
    localparam int ROM_DEPTH       = 1 << `D05_ROM_ADDR_W;

    logic                       clk;
    logic                       rst;
    logic [`D05_ROM_ADDR_W-1:0] rom_addr;
    logic [7:0]                 rom_data;
    logic                       rom_valid;
    logic [`D05_VAL_W-1:0]      part1_result;
    logic [`D05_VAL_W-1:0]      part2_result;
    logic                       done;

    logic [7:0]            rom [ROM_DEPTH];
    int                    rom_len;
    int                    value_errors;
    int                    other_errors;
    logic [63:0]           rng_state;
    logic [63:0]           lo_q [$];
    logic [63:0]           hi_q [$];
    logic [63:0]           id_q [$];

    // reads past the loaded text mean end of file
    assign rom_valid = (rom_addr < rom_len);
    assign rom_data  = rom_valid ? rom[rom_addr] : 8'h00;

    day05_top DUT (
        .clk          (clk),
        .rst          (rst),
        .rom_addr     (rom_addr),
        .rom_data     (rom_data),
        .rom_valid    (rom_valid),
        .part1_result (part1_result),
        .part2_result (part2_result),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [63:0] lcg_next();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state;
    endfunction

    task automatic clear_model();
        lo_q.delete();
        hi_q.delete();
        id_q.delete();
    endtask

    task automatic add_range(input logic [63:0] lo, input logic [63:0] hi);
        lo_q.push_back(lo);
        hi_q.push_back(hi);
    endtask

    // ids that fall inside at least one input range
    function automatic logic [63:0] model_part1();
        logic [63:0] cnt;
        cnt = 0;
        foreach (id_q[i]) begin
            foreach (lo_q[j]) begin
                if (id_q[i] >= lo_q[j] && id_q[i] <= hi_q[j]) begin
                    cnt = cnt + 1;
                    break;
                end
            end
        end
        return cnt;
    endfunction

    // size of the union of all ranges
    function automatic logic [63:0] model_part2();
        logic [63:0] slo [$];
        logic [63:0] shi [$];
        logic [63:0] tlo;
        logic [63:0] thi;
        logic [63:0] cur_lo;
        logic [63:0] cur_hi;
        logic [63:0] total;
        int          j;
        slo = lo_q;
        shi = hi_q;
        if (slo.size() == 0) begin
            return 64'd0;
        end
        for (int i = 1; i < slo.size(); i++) begin
            tlo = slo[i];
            thi = shi[i];
            j   = i - 1;
            while (j >= 0 && slo[j] > tlo) begin
                slo[j+1] = slo[j];
                shi[j+1] = shi[j];
                j--;
            end
            slo[j+1] = tlo;
            shi[j+1] = thi;
        end
        total  = 0;
        cur_lo = slo[0];
        cur_hi = shi[0];
        for (int i = 1; i < slo.size(); i++) begin
            if (slo[i] <= cur_hi) begin
                if (shi[i] > cur_hi) begin
                    cur_hi = shi[i];
                end
            end else begin
                total  = total + (cur_hi - cur_lo + 1);
                cur_lo = slo[i];
                cur_hi = shi[i];
            end
        end
        return total + (cur_hi - cur_lo + 1);
    endfunction

    function automatic string ranges_text();
        string s;
        s = "";
        foreach (lo_q[i]) begin
            s = {s, $sformatf("%0d-%0d\n", lo_q[i], hi_q[i])};
        end
        return s;
    endfunction

    function automatic string ids_text(input bit last_newline);
        string s;
        s = "";
        foreach (id_q[i]) begin
            s = {s, $sformatf("%0d", id_q[i])};
            if (i < id_q.size() - 1 || last_newline) begin
                s = {s, "\n"};
            end
        end
        return s;
    endfunction

    task automatic load_rom(input string text);
        rom_len = text.len();
        for (int i = 0; i < text.len(); i++) begin
            rom[i] = text[i];
        end
    endtask

    task automatic apply_reset(input string name);
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        if (done !== 1'b0 || part1_result !== 0 || part2_result !== 0) begin
            $display("%s: outputs not cleared after reset", name);
            other_errors++;
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %0d actual %0d", name, what, expected, actual);
            value_errors++;
        end
    endtask

    task automatic run_case(input string name, input string text,
                            input logic [63:0] exp1, input logic [63:0] exp2);
        int  cyc;
        bit  dropped;
        load_rom(text);
        apply_reset(name);
        cyc = 0;
        while (!done && cyc < DONE_TIMEOUT) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!done) begin
            $display("%s: done never arrived", name);
            other_errors++;
        end else begin
            check_value(name, "part1", exp1, part1_result);
            check_value(name, "part2", exp2, part2_result);
            dropped = 1'b0;
            repeat (10) begin
                @(posedge clk);
                #1;
                if (!done) begin
                    dropped = 1'b1;
                end
            end
            if (dropped) begin
                $display("%s: done dropped after it was raised", name);
                other_errors++;
            end
        end
    endtask

    task automatic test_sample();
        clear_model();
        add_range(3, 5);
        add_range(10, 14);
        add_range(16, 20);
        add_range(12, 18);
        id_q = '{1, 5, 8, 11, 17, 32};
        run_case("sample", {ranges_text(), "\n", ids_text(1'b1)}, 64'd3, 64'd14);
    endtask

    task automatic test_merge_rules();
        clear_model();
        add_range(30, 40);
        add_range(10, 12);
        add_range(13, 15);
        add_range(35, 38);
        add_range(30, 40);
        // 16 is left out so this one stays apart
        add_range(17, 20);
        add_range(50, 50);
        add_range(5, 9);
        id_q = '{16, 12, 13, 41, 50, 4, 5};
        run_case("merge_rules", {ranges_text(), "\n", ids_text(1'b1)},
                 model_part1(), model_part2());
    endtask

    task automatic test_input_edges();
        clear_model();
        add_range(100, 200);
        add_range(300, 300);
        add_range(150, 250);
        id_q = '{100, 250, 251, 299, 300};
        run_case("no_final_newline", {ranges_text(), "\n", ids_text(1'b0)},
                 model_part1(), model_part2());
        id_q = '{99, 201, 300, 250};
        run_case("trailing_blanks", {ranges_text(), "\n", ids_text(1'b1), "\n\n\n"},
                 model_part1(), model_part2());
    endtask

    task automatic test_short_inputs();
        clear_model();
        add_range(7, 9);
        add_range(1, 2);
        add_range(20, 29);
        run_case("no_ids", {ranges_text(), "\n"}, 64'd0, model_part2());
        // without a blank line the file ends inside the range block
        run_case("eof_in_ranges", ranges_text(), 64'd0, 64'd0);
    endtask

    task automatic test_random();
        logic [63:0] lo;
        logic [63:0] hi;
        logic [63:0] r;
        int          k;
        clear_model();
        for (int i = 0; i < 40; i++) begin
            r  = lcg_next();
            lo = {24'd0, r[63:24]};
            r  = lcg_next();
            hi = lo + {30'd0, r[63:30]};
            add_range(lo, hi);
        end
        add_range(64'hffff_ffff_ffff_ff00, 64'hffff_ffff_ffff_ffff);
        for (int i = 0; i < 60; i++) begin
            r = lcg_next();
            if (i % 2 == 0) begin
                k = (r[31:0] % lo_q.size());
                r = lcg_next();
                id_q.push_back(lo_q[k] + (r % (hi_q[k] - lo_q[k] + 1)));
            end else begin
                id_q.push_back({24'd0, r[63:24]});
            end
        end
        id_q.push_back(64'hffff_ffff_ffff_fff0);
        run_case("random", {ranges_text(), "\n", ids_text(1'b1)},
                 model_part1(), model_part2());
    endtask

    initial begin
        rst          = 1'b1;
        rom_len      = 0;
        value_errors = 0;
        other_errors = 0;
        rng_state    = 64'd65551;

        test_sample();
        test_merge_rules();
        test_input_edges();
        test_short_inputs();
        test_random();

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
day05_pkg.sv
range_ram.sv
input_parser.sv
range_sorter.sv
range_merger.sv
interval_search.sv
day05_top.sv
tb_day05.sv
